/* project.f */
src/pipe_pkg.sv
src/mem_pkg.sv
src/pipe_latch.sv
src/mem_stage.sv
src/dcache_ctrl.sv
src/mem_cfg_regs.sv
src/mem_subsys_top.sv
verification/mem_subsys_properties.sv
verification/mem_subsys_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = mem_subsys_tb
FILELIST = project.f

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

/* verification/mem_subsys_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_tb
   import pipe_pkg::*;
   import mem_pkg::*;
;
   logic clk, rst_n, flush, in_valid, cfg_we, cfg_addr, busy, out_valid;
   logic [7:0] cfg_wdata, cfg_rdata;
   me_op_t in_op;
   wb_op_t out_op;
   me_op_t next_op;
   mmx_t   shadow [DC_DEPTH];             // Expected RAM contents.
   wb_op_t exp_q [$];
   int     lat_q [$];
   int     seed = 59;
   int     cyc = 0, busy_cycles = 0, pass_cnt = 0, fail_cnt = 0;
   int     ws = 0, nloads = 0, b0;

   mem_subsys_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic wb_op_t ref_me(me_op_t op);
      wb_op_t r;
      mmx_t   d;
      d = shadow[op.rd_addr[10:3]];
      r.eip = op.eip;
      r.cs = op.cs;
      r.a = op.me_ctrl.mem_rd ? d[31:0] : op.a;
      r.b = op.me_ctrl.mux_b ? op.a : op.b;
      r.mm_a = op.me_ctrl.mem_rd ? d : op.mm_a;
      r.mm_b = op.mm_b;
      r.sp_xchg = op.me_ctrl.imm_add ? op.sp_xchg + op.b : op.sp_xchg;
      r.wr_addr = op.wr_addr;
      r.dr1_size = op.dr1_size;
      r.dr2_size = op.dr2_size;
      r.mem_size = op.mem_size;
      r.aluk = op.aluk;
      r.drid1 = op.drid1;
      r.drid2 = op.drid2;
      r.wb_ctrl = op.wb_ctrl;
      return r;
   endfunction

   function automatic me_op_t rand_op(logic rd, logic wr);
      logic [383:0] bits;
      me_op_t op;
      for (int i = 0; i < 384; i += 32) bits[i +: 32] = $random(seed);
      op = me_op_t'(bits[$bits(me_op_t)-1:0]);
      op.me_ctrl.mem_rd = rd;
      op.me_ctrl.mem_wr = wr;
      op.wb_ctrl.mem_wr = wr;
      return op;
   endfunction

   task automatic abort(string why);
      $display("%s", why);
      $display("Something failed");
      $finish;
   endtask

   // Call right after a rising edge; returns at the accepting edge.
   task automatic send(me_op_t op);
      wb_op_t r;
      int t;
      in_op <= op;
      in_valid <= 1'b1;
      t = 0;
      do begin
         @(posedge clk);
         t++;
      end while (busy && t < 200);
      if (busy) abort("Timeout waiting for the op to be accepted");
      r = ref_me(op);
      if (op.wb_ctrl.mem_wr) shadow[op.wr_addr[10:3]] = {32'b0, r.a};
      if (op.me_ctrl.mem_rd) nloads++;
      exp_q.push_back(r);
      lat_q.push_back(cyc + 2 + (op.me_ctrl.mem_rd ? ws + 1 : 0));
   endtask

   task automatic drain();
      int t;
      in_valid <= 1'b0;
      t = 0;
      while (exp_q.size() > 0 && t < 200) begin
         @(posedge clk);
         t++;
      end
      if (exp_q.size() > 0) abort("Timeout waiting for pending ops to leave WB");
   endtask

   task automatic cfg_check(logic adr, logic [7:0] want);
      cfg_addr <= adr;
      @(posedge clk);
      if (cfg_rdata !== want) begin
         $display("FAILED cfg_rdata: got %h expected %h", cfg_rdata, want);
         fail_cnt++;
      end else pass_cnt++;
   endtask

   task automatic set_ws(int w);
      cfg_we <= 1'b1;
      cfg_addr <= 1'b0;
      cfg_wdata <= 8'(w);
      @(posedge clk);
      cfg_we <= 1'b0;
      ws = w;
      cfg_check(1'b0, 8'(w));
   endtask

   task automatic report(int n, string name);
      $display("test %0d %s done, failures so far %0d", n, name, fail_cnt);
   endtask

   always @(posedge clk) begin : compare
      wb_op_t e;
      int l;
      cyc <= cyc + 1;
      if (busy) busy_cycles <= busy_cycles + 1;
      if (rst_n && out_valid) begin
         if (exp_q.size() == 0) begin
            $display("out_valid seen at cycle %0d with no op expected", cyc);
            fail_cnt++;
         end else begin
            e = exp_q.pop_front();
            l = lat_q.pop_front();
            if (out_op !== e) begin
               $display("FAILED out_op: got %h expected %h", out_op, e);
               fail_cnt++;
            end else if (cyc != l) begin
               $display("FAILED out_valid cycle: got %h expected %h", cyc, l);
               fail_cnt++;
            end else pass_cnt++;
         end
      end
   end

   initial begin
      rst_n = 1'b0;
      flush = 1'b0;
      in_valid = 1'b0;
      in_op = '0;
      cfg_we = 1'b0;
      cfg_addr = 1'b0;
      cfg_wdata = '0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      repeat (20) send(rand_op(1'b0, 1'b0));
      drain();
      report(1, "alu ops");
      for (int i = 0; i < 256; i++) begin
         next_op = rand_op(1'b0, 1'b1);
         next_op.wr_addr = i << 3;          // Every double word in turn.
         send(next_op);
      end
      for (int i = 0; i < 256; i++) begin
         next_op = rand_op(1'b1, 1'b0);
         next_op.rd_addr = i << 3;
         send(next_op);
      end
      drain();
      report(2, "store then load");
      for (int w = 0; w < 8; w += (w == 0) ? 3 : 4) begin
         set_ws(w);
         b0 = busy_cycles;
         send(rand_op(1'b1, 1'b0));
         drain();
         if (busy_cycles - b0 != w + 1) begin
            $display("FAILED busy cycles: got %h expected %h", busy_cycles - b0, w + 1);
            fail_cnt++;
         end else pass_cnt++;
      end
      report(3, "wait states");
      repeat (60) send(rand_op(1'($random(seed)), 1'($random(seed))));
      drain();
      report(4, "mixed stream");
      cfg_check(1'b1, 8'(nloads));
      report(5, "load counter");
      send(rand_op(1'b1, 1'b0));
      in_valid <= 1'b0;
      repeat (3) @(posedge clk);
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
      void'(exp_q.pop_back());
      void'(lat_q.pop_back());
      nloads--;
      repeat (10) @(posedge clk);
      send(rand_op(1'b1, 1'b0));
      drain();
      cfg_check(1'b1, 8'(nloads));
      report(6, "flush");
      $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verification/mem_subsys_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_properties (
   input logic clk,
   input logic rst_n,
   input logic flush,
   input logic dcache_en,
   input logic dcache_ready,
   input logic stall,
   input logic res_valid,
   input logic mem_rd
);

   // One read request per load.
   a_en_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      dcache_en |=> !dcache_en) else $error("dcache_en longer than one cycle");

   a_stall_end: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(stall) |-> dcache_ready || $past(flush))
      else $error("stall fell without dcache_ready");

   // A load leaves ME only with the cache answer.
   a_load_res: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid && mem_rd |-> dcache_ready)
      else $error("load result without dcache_ready");

endmodule

bind mem_stage mem_subsys_properties props (
   .clk(clk), .rst_n(rst_n), .flush(flush), .dcache_en(dcache_en),
   .dcache_ready(dcache_ready), .stall(stall), .res_valid(res_valid),
   .mem_rd(op.me_ctrl.mem_rd)
);

`default_nettype wire

/* src/mem_subsys_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top
   import pipe_pkg::*;
   import mem_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       flush,
   input  logic       in_valid,
   input  me_op_t     in_op,
   input  logic       cfg_we,
   input  logic       cfg_addr,
   input  logic [7:0] cfg_wdata,
   output logic       busy,
   output logic       out_valid,
   output wb_op_t     out_op,
   output logic [7:0] cfg_rdata
);

   logic              me_valid;
   me_op_t            me_op;
   logic              stall;
   logic              dcache_en;
   dc_index_t         rd_index;
   mmx_t              dcache_data;
   logic              dcache_ready;
   logic              load_done;
   logic              res_valid;
   wb_op_t            res;
   dc_wr_t            dc_wr;
   logic [WAIT_W-1:0] wait_states;

   assign busy = stall;

   // Store leaves WB.
   assign dc_wr = '{en:   out_valid & out_op.wb_ctrl.mem_wr,
                    addr: out_op.wr_addr,
                    data: DC_DATA_W'(out_op.a)};

   pipe_latch #(.payload_t(me_op_t)) me_latch (
      .clk(clk), .rst_n(rst_n), .flush(flush), .hold(stall),
      .in_valid(in_valid), .in_data(in_op),
      .out_valid(me_valid), .out_data(me_op)
   );

   mem_stage u_mem_stage (
      .clk(clk), .rst_n(rst_n), .flush(flush),
      .op_valid(me_valid), .op(me_op),
      .dcache_data(dcache_data), .dcache_ready(dcache_ready),
      .dcache_en(dcache_en), .rd_index(rd_index), .stall(stall),
      .load_done(load_done), .res_valid(res_valid), .res(res)
   );

   pipe_latch #(.payload_t(wb_op_t)) wb_latch (
      .clk(clk), .rst_n(rst_n), .flush(flush), .hold(1'b0),
      .in_valid(res_valid), .in_data(res),
      .out_valid(out_valid), .out_data(out_op)
   );

   dcache_ctrl u_dcache_ctrl (
      .clk(clk), .rst_n(rst_n), .rd_en(dcache_en), .rd_index(rd_index),
      .wr(dc_wr), .wait_states(wait_states),
      .rd_data(dcache_data), .rd_ready(dcache_ready)
   );

   mem_cfg_regs u_mem_cfg_regs (
      .clk(clk), .rst_n(rst_n), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
      .cfg_wdata(cfg_wdata), .load_done(load_done),
      .cfg_rdata(cfg_rdata), .wait_states(wait_states)
   );

endmodule

`default_nettype wire

/* src/mem_cfg_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_cfg_regs
   import mem_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              cfg_we,
   input  logic              cfg_addr,
   input  logic [7:0]        cfg_wdata,
   input  logic              load_done,
   output logic [7:0]        cfg_rdata,
   output logic [WAIT_W-1:0] wait_states
);

   logic [7:0] load_cnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wait_states <= '0;
         load_cnt    <= '0;
      end else begin
         if (cfg_we && cfg_addr == CFG_WAIT_ADDR) begin
            wait_states <= cfg_wdata[WAIT_W-1:0];
         end
         if (load_done) begin
            load_cnt <= load_cnt + 1'b1;  // Wraps.
         end
      end
   end

   always_comb begin
      case (cfg_addr)
         CFG_WAIT_ADDR:  cfg_rdata = 8'(wait_states);
         CFG_LDCNT_ADDR: cfg_rdata = load_cnt;
         default:        cfg_rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

/* src/dcache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl
   import pipe_pkg::*;
   import mem_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              rd_en,
   input  dc_index_t         rd_index,
   input  dc_wr_t            wr,
   input  logic [WAIT_W-1:0] wait_states,
   output mmx_t              rd_data,
   output logic              rd_ready
);

   mmx_t              ram [DC_DEPTH];
   logic              pending;
   logic [WAIT_W-1:0] wait_cnt;
   dc_index_t         rd_idx_q;

   always_ff @(posedge clk) begin
      if (wr.en) begin
         ram[dc_index(wr.addr)] <= wr.data;
      end
   end

   // A new request restarts the counter.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending  <= 1'b0;
         wait_cnt <= '0;
      end else if (rd_en) begin
         pending  <= 1'b1;
         wait_cnt <= wait_states;
      end else if (rd_ready) begin
         pending  <= 1'b0;
      end else if (pending) begin
         wait_cnt <= wait_cnt - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_idx_q <= rd_index;
      end
   end

   assign rd_ready = pending & (wait_cnt == '0);   // wait_states+1 after rd_en.
   assign rd_data  = ram[rd_idx_q];                // Sampled in the ready cycle.

endmodule

`default_nettype wire

/* src/mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage
   import pipe_pkg::*;
   import mem_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      flush,
   input  logic      op_valid,
   input  me_op_t    op,
   input  mmx_t      dcache_data,
   input  logic      dcache_ready,
   output logic      dcache_en,
   output dc_index_t rd_index,
   output logic      stall,
   output logic      load_done,
   output logic      res_valid,
   output wb_op_t    res
);

   typedef enum logic {ST_IDLE, ST_WAIT} state_t;

   state_t state;
   logic   load;
   logic   done;

   assign load = op_valid & op.me_ctrl.mem_rd;
   assign done = (state == ST_WAIT) & dcache_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else if (flush) begin
         state <= ST_IDLE;            // Late ready is ignored in idle.
      end else if (state == ST_IDLE && load) begin
         state <= ST_WAIT;
      end else if (done) begin
         state <= ST_IDLE;
      end
   end

   assign dcache_en = (state == ST_IDLE) & load;   // One read per load.
   assign rd_index  = dc_index(op.rd_addr);
   assign stall     = dcache_en | ((state == ST_WAIT) & ~dcache_ready);
   assign load_done = done;
   assign res_valid = op_valid & ~stall;

   always_comb begin
      res.eip      = op.eip;
      res.cs       = op.cs;
      res.a        = op.me_ctrl.mem_rd ? dcache_data[31:0] : op.a;
      res.b        = op.me_ctrl.mux_b ? op.a : op.b;
      res.mm_a     = op.me_ctrl.mem_rd ? dcache_data : op.mm_a;
      res.mm_b     = op.mm_b;
      // Wraps at 32 bits.
      res.sp_xchg  = op.sp_xchg + (op.me_ctrl.imm_add ? op.b : word_t'(0));
      res.wr_addr  = op.wr_addr;
      res.dr1_size = op.dr1_size;
      res.dr2_size = op.dr2_size;
      res.mem_size = op.mem_size;
      res.aluk     = op.aluk;
      res.drid1    = op.drid1;
      res.drid2    = op.drid2;
      res.wb_ctrl  = op.wb_ctrl;
   end

endmodule

`default_nettype wire

/* src/pipe_latch.sv */
`timescale 1ns/10ps
`default_nettype none

module pipe_latch #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     flush,
   input  logic     hold,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     out_valid,
   output payload_t out_data
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (flush) begin
         out_valid <= 1'b0;           // Flush beats hold.
      end else if (!hold) begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (!hold) begin
         out_data <= in_data;
      end
   end

endmodule

`default_nettype wire

/* src/mem_pkg.sv */
`default_nettype none

package mem_pkg;

   typedef logic [31:0] addr_t;

   localparam int DC_INDEX_W   = 8;
   localparam int DC_INDEX_LSB = 3;                 // Double-word granularity.
   localparam int DC_DEPTH     = 1 << DC_INDEX_W;
   localparam int DC_DATA_W    = 64;
   localparam int WAIT_W       = 4;

   localparam logic CFG_WAIT_ADDR  = 1'b0;
   localparam logic CFG_LDCNT_ADDR = 1'b1;

   typedef logic [DC_INDEX_W-1:0] dc_index_t;

   typedef struct packed {
      logic                 en;
      addr_t                addr;
      logic [DC_DATA_W-1:0] data;                   // a, zero-extended.
   } dc_wr_t;

   // No tags. The address indexes the RAM directly.
   function automatic dc_index_t dc_index(addr_t addr);
      return addr[DC_INDEX_LSB +: DC_INDEX_W];
   endfunction

endpackage

`default_nettype wire

/* src/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

   typedef logic [31:0] eip_t;
   typedef logic [15:0] cs_t;
   typedef logic [31:0] word_t;
   typedef logic [63:0] mmx_t;
   typedef logic [1:0]  size_t;
   typedef logic [2:0]  drid_t;
   typedef logic [2:0]  aluk_t;

   // Bits decoded in ME.
   typedef struct packed {
      logic mem_rd;                   // Load from the data cache.
      logic mux_b;                    // b takes a.
      logic imm_add;                  // sp_xchg gets b added.
      logic mem_wr;
   } me_ctrl_t;

   typedef struct packed {
      logic mem_wr;                   // Store a in WB.
      logic ld_gpr1;
      logic ld_mm;
   } wb_ctrl_t;

   typedef struct packed {
      eip_t     eip;
      cs_t      cs;
      word_t    a;
      word_t    b;
      mmx_t     mm_a;
      mmx_t     mm_b;
      word_t    sp_xchg;
      word_t    rd_addr;
      word_t    wr_addr;
      size_t    dr1_size;
      size_t    dr2_size;
      size_t    mem_size;
      aluk_t    aluk;
      drid_t    drid1;
      drid_t    drid2;
      me_ctrl_t me_ctrl;
      wb_ctrl_t wb_ctrl;
   } me_op_t;

   typedef struct packed {
      eip_t     eip;
      cs_t      cs;
      word_t    a;
      word_t    b;
      mmx_t     mm_a;
      mmx_t     mm_b;
      word_t    sp_xchg;
      word_t    wr_addr;
      size_t    dr1_size;
      size_t    dr2_size;
      size_t    mem_size;
      aluk_t    aluk;
      drid_t    drid1;
      drid_t    drid2;
      wb_ctrl_t wb_ctrl;
   } wb_op_t;

endpackage

`default_nettype wire
